// File: verilog/cvx_defines.svh
// ==================================================
// CVX core shared parameters
// Register file size, register index width and the
// width of the retirement counters
// ==================================================

`ifndef CVX_DEFINES_SVH
`define CVX_DEFINES_SVH

// Architectural registers x0..x7
`define CVX_NUM_REGS 8

// Bits needed to address one register
`define CVX_REG_W 3

// Retired and illegal instruction counters
`define CVX_CNT_W 16

`endif

// File: verilog/cvx_pkg.sv
// ==================================================
// CVX core package
// Word and register index types, major opcodes,
// fetch states and the retirement trace record
// ==================================================

`default_nettype none

`include "cvx_defines.svh"

package cvx_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`CVX_REG_W-1:0] reg_idx_t;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_RVALID,
        SLEEP
    } fetch_state_e;

    // One retired instruction
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    instr;
        logic     we;
        reg_idx_t rd;
        word_t    wdata;
        logic     illegal;
        logic     sleep;
    } trace_t;

endpackage

`default_nettype wire

// File: verilog/cvx_fetch.sv
// ==================================================
// CVX instruction fetch
// Runs the req/gnt/rvalid instruction port, keeps
// the PC and hands each returned word to execute
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module cvx_fetch (
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire logic          fetch_enable_i,
    input  cvx_pkg::word_t     boot_addr_i,
    input  wire logic          halt_i,
    output logic               instr_req_o,
    input  wire logic          instr_gnt_i,
    input  wire logic          instr_rvalid_i,
    output cvx_pkg::word_t     instr_addr_o,
    input  cvx_pkg::word_t     instr_rdata_i,
    output logic               fetch_valid_o,
    output cvx_pkg::word_t     fetch_pc_o,
    output cvx_pkg::word_t     fetch_instr_o,
    output logic               sleep_o
);

    cvx_pkg::fetch_state_e state_q, state_d;
    cvx_pkg::word_t        pc_q, pc_d;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            cvx_pkg::IDLE: begin
                if (fetch_enable_i) begin
                    state_d = cvx_pkg::REQ;
                end
            end
            cvx_pkg::REQ: begin
                if (instr_gnt_i) begin
                    state_d = cvx_pkg::WAIT_RVALID;
                end
            end
            cvx_pkg::WAIT_RVALID: begin
                // Word retires in this cycle, ECALL stops fetching for good
                if (instr_rvalid_i) begin
                    if (halt_i) begin
                        state_d = cvx_pkg::SLEEP;
                    end else begin
                        state_d = cvx_pkg::REQ;
                        pc_d    = pc_q + 32'd4;
                    end
                end
            end
            cvx_pkg::SLEEP: state_d = cvx_pkg::SLEEP;
            default:        state_d = cvx_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= cvx_pkg::IDLE;
            pc_q    <= boot_addr_i;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign instr_req_o   = (state_q == cvx_pkg::REQ);
    assign instr_addr_o  = pc_q;
    assign fetch_valid_o = (state_q == cvx_pkg::WAIT_RVALID) && instr_rvalid_i;
    assign fetch_pc_o    = pc_q;
    assign fetch_instr_o = instr_rdata_i;
    assign sleep_o       = (state_q == cvx_pkg::SLEEP);

    // A pending request keeps its address until granted
    a_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
        else $error("instr_addr_o changed while request was pending");

    a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_rvalid_i |-> (state_q == cvx_pkg::WAIT_RVALID))
        else $error("instr_rvalid_i without an outstanding request");

endmodule

`default_nettype wire

// File: verilog/cvx_execute.sv
// ==================================================
// CVX execute stage
// Decodes the RV32I subset, reads and writes the
// x0..x7 register file and builds the trace record
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "cvx_defines.svh"

module cvx_execute (
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire logic          fetch_valid_i,
    input  cvx_pkg::word_t     fetch_pc_i,
    input  cvx_pkg::word_t     fetch_instr_i,
    output logic               halt_o,
    output cvx_pkg::trace_t    trace_o
);

    cvx_pkg::word_t    rf_q [`CVX_NUM_REGS];
    cvx_pkg::opcode_e  opcode;
    logic [4:0]        rd_f, rs1_f, rs2_f;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    cvx_pkg::reg_idx_t rd_idx, rs1_idx, rs2_idx;
    cvx_pkg::word_t    rs1_val, rs2_val, imm_i, imm_u, result;
    logic              uses_rs1, uses_rs2, writes_rd;
    logic              is_ecall, illegal, rf_we;

    // Instruction fields
    assign opcode  = cvx_pkg::opcode_e'(fetch_instr_i[6:0]);
    assign rd_f    = fetch_instr_i[11:7];
    assign funct3  = fetch_instr_i[14:12];
    assign rs1_f   = fetch_instr_i[19:15];
    assign rs2_f   = fetch_instr_i[24:20];
    assign funct7  = fetch_instr_i[31:25];
    assign imm_i   = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
    assign imm_u   = {fetch_instr_i[31:12], 12'b0};
    assign rd_idx  = rd_f[`CVX_REG_W-1:0];
    assign rs1_idx = rs1_f[`CVX_REG_W-1:0];
    assign rs2_idx = rs2_f[`CVX_REG_W-1:0];

    // x0 is hardwired to zero
    assign rs1_val = (rs1_idx == '0) ? '0 : rf_q[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : rf_q[rs2_idx];

    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        is_ecall  = 1'b0;
        illegal   = 1'b0;
        result    = '0;
        case (opcode)
            cvx_pkg::OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: result = rs1_val + rs2_val;
                    {7'h20, 3'b000}: result = rs1_val - rs2_val;
                    {7'h00, 3'b111}: result = rs1_val & rs2_val;
                    {7'h00, 3'b110}: result = rs1_val | rs2_val;
                    {7'h00, 3'b100}: result = rs1_val ^ rs2_val;
                    default:         illegal = 1'b1;
                endcase
            end
            cvx_pkg::OP_IMM: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                // Only ADDI among the immediate ops
                if (funct3 == 3'b000) begin
                    result = rs1_val + imm_i;
                end else begin
                    illegal = 1'b1;
                end
            end
            cvx_pkg::LUI: begin
                writes_rd = 1'b1;
                result    = imm_u;
            end
            cvx_pkg::SYSTEM: begin
                if (fetch_instr_i[31:7] == '0) begin
                    is_ecall = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
        // Registers above x7 do not exist
        if ((uses_rs1 && rs1_f >= 5'(`CVX_NUM_REGS)) ||
            (uses_rs2 && rs2_f >= 5'(`CVX_NUM_REGS)) ||
            (writes_rd && rd_f >= 5'(`CVX_NUM_REGS))) begin
            illegal = 1'b1;
        end
    end

    assign rf_we = fetch_valid_i && writes_rd && !illegal && (rd_idx != '0);

    always_ff @(posedge clk_i) begin
        if (!reset_i && rf_we) begin
            rf_q[rd_idx] <= result;
        end
    end

    assign halt_o = is_ecall;

    always_comb begin
        trace_o.valid   = fetch_valid_i;
        trace_o.pc      = fetch_pc_i;
        trace_o.instr   = fetch_instr_i;
        trace_o.we      = rf_we;
        trace_o.rd      = rd_idx;
        trace_o.wdata   = result;
        trace_o.illegal = illegal;
        trace_o.sleep   = is_ecall;
    end

endmodule

`default_nettype wire

// File: verilog/cvx_core.sv
// ==================================================
// CVX core
// Fetch unit feeding the execute stage, with the
// ECALL halt path and the retirement trace
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module cvx_core (
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire logic          fetch_enable_i,
    input  cvx_pkg::word_t     boot_addr_i,
    output logic               instr_req_o,
    input  wire logic          instr_gnt_i,
    input  wire logic          instr_rvalid_i,
    output cvx_pkg::word_t     instr_addr_o,
    input  cvx_pkg::word_t     instr_rdata_i,
    output logic               core_sleep_o,
    output cvx_pkg::trace_t    trace_o
);

    logic           fetch_valid;
    cvx_pkg::word_t fetch_pc;
    cvx_pkg::word_t fetch_instr;
    logic           halt;

    cvx_fetch fetch_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fetch_enable_i (fetch_enable_i),
        .boot_addr_i    (boot_addr_i),
        .halt_i         (halt),
        .instr_req_o    (instr_req_o),
        .instr_gnt_i    (instr_gnt_i),
        .instr_rvalid_i (instr_rvalid_i),
        .instr_addr_o   (instr_addr_o),
        .instr_rdata_i  (instr_rdata_i),
        .fetch_valid_o  (fetch_valid),
        .fetch_pc_o     (fetch_pc),
        .fetch_instr_o  (fetch_instr),
        .sleep_o        (core_sleep_o)
    );

    // Retires in the rvalid cycle, halt goes straight back to fetch
    cvx_execute execute_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .fetch_instr_i (fetch_instr),
        .halt_o        (halt),
        .trace_o       (trace_o)
    );

endmodule

`default_nettype wire

// File: verilog/cvx_trace_log.sv
// ==================================================
// CVX trace logger
// Registers the retirement record and keeps
// saturating retired and illegal counters
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "cvx_defines.svh"

module cvx_trace_log (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  cvx_pkg::trace_t         trace_i,
    output cvx_pkg::trace_t         trace_o,
    output logic [`CVX_CNT_W-1:0]   retired_cnt_o,
    output logic [`CVX_CNT_W-1:0]   illegal_cnt_o
);

    logic                  valid_q;
    cvx_pkg::trace_t       record_q;
    logic [`CVX_CNT_W-1:0] retired_cnt_q;
    logic [`CVX_CNT_W-1:0] illegal_cnt_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q       <= 1'b0;
            retired_cnt_q <= '0;
            illegal_cnt_q <= '0;
        end else begin
            valid_q <= trace_i.valid;
            // Counters stop at all ones
            if (trace_i.valid && (retired_cnt_q != '1)) begin
                retired_cnt_q <= retired_cnt_q + 1'b1;
            end
            if (trace_i.valid && trace_i.illegal && (illegal_cnt_q != '1)) begin
                illegal_cnt_q <= illegal_cnt_q + 1'b1;
            end
        end
    end

    // Payload holds the last retirement between valid cycles
    always_ff @(posedge clk_i) begin
        if (trace_i.valid) begin
            record_q <= trace_i;
        end
    end

    always_comb begin
        trace_o       = record_q;
        trace_o.valid = valid_q;
    end

    assign retired_cnt_o = retired_cnt_q;
    assign illegal_cnt_o = illegal_cnt_q;

    a_illegal_no_write: assert property (@(posedge clk_i) disable iff (reset_i)
        (trace_i.valid && trace_i.illegal) |-> !trace_i.we)
        else $error("illegal retirement wrote a register");

endmodule

`default_nettype wire

// File: verilog/cvx_wrapper.sv
// ==================================================
// CVX top level
// Core plus trace logger, exporting the registered
// retirement trace and its counters
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "cvx_defines.svh"

module cvx_wrapper (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic               fetch_enable_i,
    input  cvx_pkg::word_t          boot_addr_i,
    output logic                    instr_req_o,
    input  wire logic               instr_gnt_i,
    input  wire logic               instr_rvalid_i,
    output cvx_pkg::word_t          instr_addr_o,
    input  cvx_pkg::word_t          instr_rdata_i,
    output logic                    core_sleep_o,
    output cvx_pkg::trace_t         trace_o,
    output logic [`CVX_CNT_W-1:0]   retired_cnt_o,
    output logic [`CVX_CNT_W-1:0]   illegal_cnt_o
);

    cvx_pkg::trace_t core_trace;

    cvx_core core_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fetch_enable_i (fetch_enable_i),
        .boot_addr_i    (boot_addr_i),
        .instr_req_o    (instr_req_o),
        .instr_gnt_i    (instr_gnt_i),
        .instr_rvalid_i (instr_rvalid_i),
        .instr_addr_o   (instr_addr_o),
        .instr_rdata_i  (instr_rdata_i),
        .core_sleep_o   (core_sleep_o),
        .trace_o        (core_trace)
    );

    cvx_trace_log trace_log_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .trace_i       (core_trace),
        .trace_o       (trace_o),
        .retired_cnt_o (retired_cnt_o),
        .illegal_cnt_o (illegal_cnt_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_cvx_wrapper.sv
// ==================================================
// CVX wrapper testbench
// Instruction memory with random grant and rvalid
// delays, a reference model of the register file
// and a checker on the registered retirement trace
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "cvx_defines.svh"

module tb_cvx_wrapper;

    localparam cvx_pkg::word_t BOOT_ADDR = 32'h0000_1000;
    localparam cvx_pkg::word_t ECALL     = 32'h0000_0073;
    localparam int PROG_LEN        = 48;
    localparam int IDLE_CYCLES     = 6;
    localparam int WORST_FETCH     = 10;
    localparam int TAIL_CYCLES     = 12;
    localparam int WATCHDOG_CYCLES = 4 + IDLE_CYCLES + PROG_LEN * WORST_FETCH + TAIL_CYCLES + 50;

    logic                  clk_i;
    logic                  reset_i;
    logic                  fetch_enable_i;
    cvx_pkg::word_t        boot_addr_i;
    logic                  instr_req_o;
    logic                  instr_gnt_i;
    logic                  instr_rvalid_i;
    cvx_pkg::word_t        instr_addr_o;
    cvx_pkg::word_t        instr_rdata_i;
    logic                  core_sleep_o;
    cvx_pkg::trace_t       trace_o;
    logic [`CVX_CNT_W-1:0] retired_cnt_o;
    logic [`CVX_CNT_W-1:0] illegal_cnt_o;

    cvx_pkg::word_t prog [64];
    cvx_pkg::word_t shadow [8];
    logic [31:0]    lfsr_q = 32'h2fac;
    int             exp_illegal = 0;
    int             retired_seen = 0;
    int             checks = 0;
    int             errors = 0;

    cvx_wrapper cvx_wrapper_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fetch_enable_i (fetch_enable_i),
        .boot_addr_i    (boot_addr_i),
        .instr_req_o    (instr_req_o),
        .instr_gnt_i    (instr_gnt_i),
        .instr_rvalid_i (instr_rvalid_i),
        .instr_addr_o   (instr_addr_o),
        .instr_rdata_i  (instr_rdata_i),
        .core_sleep_o   (core_sleep_o),
        .trace_o        (trace_o),
        .retired_cnt_o  (retired_cnt_o),
        .illegal_cnt_o  (illegal_cnt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic cvx_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic cvx_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // Register setup first, then a random mix, then ECALL
    task automatic build_program;
        logic [2:0] kind;
        logic [2:0] sel;
        logic [4:0] rd, rs1, rs2;
        prog[0] = i_type(12'h055, 5'd0, 3'd0, 5'd0);
        for (int k = 1; k < 8; k++) begin
            prog[6'(k)] = i_type(12'(take_bits(12)), 5'd0, 3'd0, 5'(k));
        end
        for (int k = 8; k < PROG_LEN - 1; k++) begin
            kind = 3'(take_bits(3));
            rd   = {2'b00, 3'(take_bits(3))};
            rs1  = {2'b00, 3'(take_bits(3))};
            rs2  = {2'b00, 3'(take_bits(3))};
            sel  = 3'(take_bits(3)) % 3'd5;
            case (kind)
                3'd0, 3'd1, 3'd2: begin
                    case (sel)
                        3'd0:    prog[6'(k)] = r_type(7'h00, rs2, rs1, 3'd0, rd);
                        3'd1:    prog[6'(k)] = r_type(7'h20, rs2, rs1, 3'd0, rd);
                        3'd2:    prog[6'(k)] = r_type(7'h00, rs2, rs1, 3'd7, rd);
                        3'd3:    prog[6'(k)] = r_type(7'h00, rs2, rs1, 3'd6, rd);
                        default: prog[6'(k)] = r_type(7'h00, rs2, rs1, 3'd4, rd);
                    endcase
                end
                3'd3: prog[6'(k)] = i_type(12'(take_bits(12)), rs1, 3'd0, rd);
                3'd4: prog[6'(k)] = {20'(take_bits(20)), rd, 7'b0110111};
                // rs2 in x8..x15
                3'd5: prog[6'(k)] = r_type(7'h00, rs2 | 5'd8, rs1, 3'd0, rd);
                // SLTI is not in the subset
                3'd6: prog[6'(k)] = i_type(12'(take_bits(12)), rs1, 3'd2, rd);
                // Load opcode
                default: prog[6'(k)] = {12'(take_bits(12)), rs1, 3'd2, rd, 7'b0000011};
            endcase
            if (kind >= 3'd5) begin
                exp_illegal++;
            end
        end
        prog[6'(PROG_LEN - 1)] = ECALL;
    endtask

    // Expected retirement of one word, updating the shadow registers
    function automatic cvx_pkg::trace_t predict_retire(input cvx_pkg::word_t pc,
                                                       input cvx_pkg::word_t instr);
        cvx_pkg::trace_t t;
        logic [4:0]      rd, rs1, rs2;
        cvx_pkg::word_t  a, b, v;
        logic            ok, wr;
        rd  = instr[11:7];
        rs1 = instr[19:15];
        rs2 = instr[24:20];
        a   = (rs1 < 5'd8) ? shadow[rs1[2:0]] : '0;
        b   = (rs2 < 5'd8) ? shadow[rs2[2:0]] : '0;
        v   = '0;
        ok  = 1'b0;
        wr  = 1'b1;
        case (instr[6:0])
            7'b0110011: begin
                ok = (rd < 5'd8) && (rs1 < 5'd8) && (rs2 < 5'd8);
                if (instr[31:25] == 7'h20 && instr[14:12] == 3'd0) begin
                    v = a - b;
                end else if (instr[31:25] != 7'h00) begin
                    ok = 1'b0;
                end else if (instr[14:12] == 3'd0) begin
                    v = a + b;
                end else if (instr[14:12] == 3'd7) begin
                    v = a & b;
                end else if (instr[14:12] == 3'd6) begin
                    v = a | b;
                end else if (instr[14:12] == 3'd4) begin
                    v = a ^ b;
                end else begin
                    ok = 1'b0;
                end
            end
            7'b0010011: begin
                ok = (instr[14:12] == 3'd0) && (rd < 5'd8) && (rs1 < 5'd8);
                v  = a + {{20{instr[31]}}, instr[31:20]};
            end
            7'b0110111: begin
                ok = (rd < 5'd8);
                v  = {instr[31:12], 12'h000};
            end
            7'b1110011: begin
                ok = (instr == ECALL);
                wr = 1'b0;
            end
            default: ok = 1'b0;
        endcase
        t         = '0;
        t.valid   = 1'b1;
        t.pc      = pc;
        t.instr   = instr;
        t.we      = ok && wr && (rd != 5'd0);
        t.rd      = rd[2:0];
        t.wdata   = v;
        t.illegal = !ok;
        t.sleep   = (instr == ECALL);
        if (t.we) begin
            shadow[rd[2:0]] = v;
        end
        return t;
    endfunction

    task automatic flag_mismatch(input string what, input cvx_pkg::word_t got,
                                 input cvx_pkg::word_t expected);
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
        errors++;
    endtask

    function automatic cvx_pkg::word_t served_word(input cvx_pkg::word_t addr);
        cvx_pkg::word_t idx;
        idx = (addr - BOOT_ADDR) >> 2;
        if (addr < BOOT_ADDR || addr[1:0] != 2'b00 || idx >= 32'(PROG_LEN)) begin
            $display("Fetch outside the program at address %h, time %0t", addr, $time);
            errors++;
            return ECALL;
        end
        return prog[idx[5:0]];
    endfunction

    // Instruction memory, one outstanding request
    initial begin : memory_model
        int             d;
        cvx_pkg::word_t addr;
        @(negedge clk_i);
        forever begin
            if (!reset_i && instr_req_o) begin
                d = int'(take_bits(2));
                repeat (d) @(negedge clk_i);
                instr_gnt_i = 1'b1;
                addr        = instr_addr_o;
                @(negedge clk_i);
                instr_gnt_i = 1'b0;
                d = int'(take_bits(2));
                repeat (d) @(negedge clk_i);
                instr_rvalid_i = 1'b1;
                instr_rdata_i  = served_word(addr);
                @(negedge clk_i);
                instr_rvalid_i = 1'b0;
                instr_rdata_i  = '0;
            end else begin
                @(negedge clk_i);
            end
        end
    end

    initial begin : compare_trace
        cvx_pkg::trace_t exp_t;
        forever begin
            @(negedge clk_i);
            if (!reset_i && trace_o.valid) begin
                if (retired_seen >= PROG_LEN) begin
                    $display("Retirement after the final ECALL at time %0t", $time);
                    errors++;
                end else begin
                    exp_t = predict_retire(BOOT_ADDR + 32'(retired_seen * 4),
                                           prog[6'(retired_seen)]);
                    checks++;
                    if (trace_o.pc !== exp_t.pc) flag_mismatch("pc", trace_o.pc, exp_t.pc);
                    if (trace_o.instr !== exp_t.instr) begin
                        flag_mismatch("instr", trace_o.instr, exp_t.instr);
                    end
                    if (trace_o.we !== exp_t.we) begin
                        flag_mismatch("we", 32'(trace_o.we), 32'(exp_t.we));
                    end
                    if (trace_o.illegal !== exp_t.illegal) begin
                        flag_mismatch("illegal", 32'(trace_o.illegal), 32'(exp_t.illegal));
                    end
                    if (trace_o.sleep !== exp_t.sleep) begin
                        flag_mismatch("sleep", 32'(trace_o.sleep), 32'(exp_t.sleep));
                    end
                    if (exp_t.we && trace_o.rd !== exp_t.rd) begin
                        flag_mismatch("rd", 32'(trace_o.rd), 32'(exp_t.rd));
                    end
                    if (exp_t.we && trace_o.wdata !== exp_t.wdata) begin
                        flag_mismatch("wdata", trace_o.wdata, exp_t.wdata);
                    end
                end
                retired_seen++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout after %0d cycles, the core never went to sleep", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main_sequence
        logic [`CVX_CNT_W-1:0] exp_retired;
        logic [`CVX_CNT_W-1:0] exp_illegal_cnt;
        reset_i        = 1'b1;
        fetch_enable_i = 1'b0;
        boot_addr_i    = BOOT_ADDR;
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        for (int r = 0; r < 8; r++) begin
            shadow[r] = '0;
        end
        build_program();
        exp_retired     = `CVX_CNT_W'(PROG_LEN);
        exp_illegal_cnt = `CVX_CNT_W'(exp_illegal);
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;

        // Fetch must stay quiet until enabled
        repeat (IDLE_CYCLES) begin
            @(negedge clk_i);
            if (instr_req_o !== 1'b0) begin
                $display("Request made while fetch_enable_i is low, time %0t", $time);
                errors++;
            end
            if (core_sleep_o !== 1'b0 || trace_o.valid !== 1'b0) begin
                $display("Sleep or trace valid set before fetch was enabled");
                errors++;
            end
        end
        fetch_enable_i = 1'b1;

        while (core_sleep_o !== 1'b1) @(negedge clk_i);
        repeat (TAIL_CYCLES) begin
            @(negedge clk_i);
            if (instr_req_o !== 1'b0) begin
                $display("Request made after ECALL retired, time %0t", $time);
                errors++;
            end
            if (core_sleep_o !== 1'b1) begin
                $display("core_sleep_o dropped after ECALL, time %0t", $time);
                errors++;
            end
        end

        if (retired_seen != PROG_LEN) begin
            flag_mismatch("retirements seen", 32'(retired_seen), 32'(PROG_LEN));
        end
        if (retired_cnt_o !== exp_retired) begin
            flag_mismatch("retired_cnt_o", 32'(retired_cnt_o), 32'(exp_retired));
        end
        if (illegal_cnt_o !== exp_illegal_cnt) begin
            flag_mismatch("illegal_cnt_o", 32'(illegal_cnt_o), 32'(exp_illegal_cnt));
        end

        $display("Retirements checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/cvx_pkg.sv
verilog/cvx_fetch.sv
verilog/cvx_execute.sv
verilog/cvx_core.sv
verilog/cvx_trace_log.sv
verilog/cvx_wrapper.sv
tests/tb_cvx_wrapper.sv

// File: Makefile
# Verilator flow for the CVX core subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module cvx_wrapper

# A crashed run leaves no verdict line, so one is appended to the log
sim:
	verilator --binary --timing --assert -f list.f --top-module tb_cvx_wrapper \
		-o tb_cvx_wrapper
	./obj_dir/tb_cvx_wrapper > sim.log 2>&1 || echo "*** TEST FAILED ***" >> sim.log
	cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
